// ==== run_sim.sh ====
#!/bin/sh
# build and run the board testbench with Verilator, log goes to sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module board_tb -f sim.f -o board_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/board_sim > sim.log 2>&1
sim_status=$?
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status, see sim.log"
	exit 1
fi

if grep -q "Result: PASSED" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi

// ==== sim.f ====
+incdir+src
src/board_pkg.sv
src/key_panel.sv
src/uart_rx.sv
src/uart_tx.sv
src/seg_scan.sv
src/board_top.sv
test/board_checker.sv
test/board_tb.sv

// ==== src/board_config.svh ====
// timing constants in sys_clk cycles, shortened for simulation
// scale CLKS_PER_BIT, DEBOUNCE_CLKS and SCAN_CLKS up for a real board clock
// DEBOUNCE_CLKS must be at least 4, TONE_HALF and SCAN_CLKS at least 2
`ifndef BOARD_CONFIG_SVH
`define BOARD_CONFIG_SVH

// uart bit period, 8N1 framing
`define CLKS_PER_BIT 16

// a raw key level must hold this long before it counts
`define DEBOUNCE_CLKS 40

// dwell time of each display digit
`define SCAN_CLKS 8

// buzzer beep length after a press
`define BEEP_CLKS 200

// half period of the buzzer tone
`define TONE_HALF 5

`endif

// ==== src/board_pkg.sv ====
// shared types of the board controller
// digit codes 0..9 and 12..15 show hex glyphs, 10 is blank, 11 is a dash
package board_pkg;

	// uart data byte, also the led vector
	typedef logic [7:0] byte_t;

	// one display digit code
	typedef logic [3:0] digit_t;

	// active-low segments, bit 7 is dp, bits 6..0 are g..a
	typedef logic [7:0] seg_t;

	// one bit per push key, active low
	typedef logic [3:0] key_t;

	// wrapping press counter
	typedef logic [3:0] count_t;

	// special digit codes
	localparam digit_t digit_blank = 4'd10;
	localparam digit_t digit_dash  = 4'd11;
	localparam digit_t digit_f     = 4'd15;

	typedef enum logic [1:0] {
		rx_st_idle,
		rx_st_start,
		rx_st_data,
		rx_st_stop
	} rx_state_t;

	typedef enum logic [1:0] {
		tx_st_idle,
		tx_st_start,
		tx_st_data,
		tx_st_stop
	} tx_state_t;

endpackage

// ==== src/board_top.sv ====
// board controller top, keys and leds active as on the board
// a byte received while the transmitter is busy is displayed but not echoed
module board_top import board_pkg::*; (
	input  logic  sys_clk,
	input  logic  sys_rst_n,
	input  key_t  key_in,
	input  logic  uart_rx_port,
	output logic  bepeer,
	output byte_t led,
	output seg_t  seg_number,
	output byte_t seg_choice,
	output logic  uart_tx_port
);

	count_t press_count;
	byte_t  rx_data;
	logic   rx_valid;
	byte_t  last_rx;
	byte_t  tx_data;
	logic   tx_start;
	logic   tx_ready;
	digit_t disp_digit [8];

	key_panel u_key_panel (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.key_in      (key_in),
		.led         (led),
		.press_count (press_count),
		.bepeer      (bepeer)
	);

	uart_rx u_uart_rx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.uart_rx_port (uart_rx_port),
		.rx_data      (rx_data),
		.rx_valid     (rx_valid)
	);

	// echo only when the transmitter is idle
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			last_rx  <= '0;
			tx_start <= 1'b0;
		end else begin
			tx_start <= rx_valid && tx_ready;
			if (rx_valid) begin
				last_rx <= rx_data;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rx_valid) begin
			tx_data <= rx_data;
		end
	end

	uart_tx u_uart_tx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_start     (tx_start),
		.tx_data      (tx_data),
		.tx_ready     (tx_ready),
		.uart_tx_port (uart_tx_port)
	);

	// display layout, digit 7 leftmost: F, blank, dash, count, blank, blank, rx hi, rx lo
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			disp_digit[7] <= digit_f;
			disp_digit[6] <= digit_blank;
			for (int i = 0; i < 6; i++) begin
				disp_digit[i] <= digit_dash;
			end
		end else begin
			disp_digit[7] <= digit_f;
			disp_digit[6] <= digit_blank;
			disp_digit[5] <= digit_dash;
			disp_digit[4] <= press_count;
			disp_digit[3] <= digit_blank;
			disp_digit[2] <= digit_blank;
			disp_digit[1] <= last_rx[7:4];
			disp_digit[0] <= last_rx[3:0];
		end
	end

	seg_scan u_seg_scan (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.digit0     (disp_digit[0]),
		.digit1     (disp_digit[1]),
		.digit2     (disp_digit[2]),
		.digit3     (disp_digit[3]),
		.digit4     (disp_digit[4]),
		.digit5     (disp_digit[5]),
		.digit6     (disp_digit[6]),
		.digit7     (disp_digit[7]),
		.seg_number (seg_number),
		.seg_choice (seg_choice)
	);

endmodule

// ==== src/key_panel.sv ====
// four active-low keys, debounce time counts the two sync flops too
// keys pressed in the same cycle count as one press
// a new press restarts the beep
`include "board_config.svh"

module key_panel import board_pkg::*; (
	input  logic   sys_clk,
	input  logic   sys_rst_n,
	input  key_t   key_in,
	output byte_t  led,
	output count_t press_count,
	output logic   bepeer
);

	localparam int DB_W   = $clog2(`DEBOUNCE_CLKS);
	localparam int BEEP_W = $clog2(`BEEP_CLKS + 1);
	localparam int TONE_W = $clog2(`TONE_HALF + 1);

	key_t              key_s1;
	key_t              key_s2;
	key_t              key_deb;
	key_t              key_fall;
	key_t              led_state;
	logic [DB_W-1:0]   db_cnt [4];
	logic [BEEP_W-1:0] beep_left;
	logic [TONE_W-1:0] tone_cnt;

	// two-flop sync, keys idle high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			key_s1 <= '1;
			key_s2 <= '1;
		end else begin
			key_s1 <= key_in;
			key_s2 <= key_s1;
		end
	end

	// stable-count debounce per key, falling edge flags a press
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			key_deb  <= '1;
			key_fall <= '0;
			for (int i = 0; i < 4; i++) begin
				db_cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 4; i++) begin
				key_fall[i] <= 1'b0;
				if (key_s2[i] == key_deb[i]) begin
					db_cnt[i] <= '0;
				end else if (db_cnt[i] == DB_W'(`DEBOUNCE_CLKS - 3)) begin
					// three cycles already spent in sync and this compare
					db_cnt[i]   <= '0;
					key_deb[i]  <= key_s2[i];
					key_fall[i] <= ~key_s2[i];
				end else begin
					db_cnt[i] <= db_cnt[i] + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			led_state   <= '0;
			press_count <= '0;
		end else if (|key_fall) begin
			led_state   <= led_state ^ key_fall;
			press_count <= press_count + 1'b1;
		end
	end

	assign led = {press_count, led_state};

	// beep timer gates the tone divider
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			beep_left <= '0;
			tone_cnt  <= '0;
			bepeer    <= 1'b0;
		end else if (|key_fall) begin
			beep_left <= BEEP_W'(`BEEP_CLKS);
			tone_cnt  <= '0;
			bepeer    <= 1'b0;
		end else if (beep_left != '0) begin
			beep_left <= beep_left - 1'b1;
			if (tone_cnt == TONE_W'(`TONE_HALF - 1)) begin
				tone_cnt <= '0;
				bepeer   <= ~bepeer;
			end else begin
				tone_cnt <= tone_cnt + 1'b1;
			end
		end else begin
			tone_cnt <= '0;
			bepeer   <= 1'b0;
		end
	end

endmodule

// ==== src/seg_scan.sv ====
// eight-digit multiplexed display, common anode, all outputs active low
// digit 0 is selected first after reset and shows blank for one cycle
`include "board_config.svh"

module seg_scan import board_pkg::*; (
	input  logic   sys_clk,
	input  logic   sys_rst_n,
	input  digit_t digit0,
	input  digit_t digit1,
	input  digit_t digit2,
	input  digit_t digit3,
	input  digit_t digit4,
	input  digit_t digit5,
	input  digit_t digit6,
	input  digit_t digit7,
	output seg_t   seg_number,
	output byte_t  seg_choice
);

	localparam int SCAN_W = $clog2(`SCAN_CLKS);

	logic [SCAN_W-1:0] scan_cnt;
	logic [2:0]        scan_idx;
	logic [2:0]        scan_next;
	digit_t            cur_digit;

	// segments g..a active high, inverted on the way out
	function automatic seg_t glyph(input digit_t code);
		logic [6:0] lit;
		case (code)
			4'd0:        lit = 7'h3f;
			4'd1:        lit = 7'h06;
			4'd2:        lit = 7'h5b;
			4'd3:        lit = 7'h4f;
			4'd4:        lit = 7'h66;
			4'd5:        lit = 7'h6d;
			4'd6:        lit = 7'h7d;
			4'd7:        lit = 7'h07;
			4'd8:        lit = 7'h7f;
			4'd9:        lit = 7'h6f;
			digit_blank: lit = 7'h00;
			digit_dash:  lit = 7'h40;
			4'd12:       lit = 7'h39;
			4'd13:       lit = 7'h5e;
			4'd14:       lit = 7'h79;
			default:     lit = 7'h71;
		endcase
		return {1'b1, ~lit};
	endfunction

	assign scan_next = (scan_cnt == SCAN_W'(`SCAN_CLKS - 1)) ? scan_idx + 1'b1 : scan_idx;

	always_comb begin
		case (scan_next)
			3'd0:    cur_digit = digit0;
			3'd1:    cur_digit = digit1;
			3'd2:    cur_digit = digit2;
			3'd3:    cur_digit = digit3;
			3'd4:    cur_digit = digit4;
			3'd5:    cur_digit = digit5;
			3'd6:    cur_digit = digit6;
			default: cur_digit = digit7;
		endcase
	end

	// select and glyph registered from the same index
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			scan_cnt   <= '0;
			scan_idx   <= '0;
			seg_choice <= 8'hfe;
			seg_number <= 8'hff;
		end else begin
			scan_cnt   <= (scan_cnt == SCAN_W'(`SCAN_CLKS - 1)) ? '0 : scan_cnt + 1'b1;
			scan_idx   <= scan_next;
			seg_choice <= ~(byte_t'(1) << scan_next);
			seg_number <= glyph(cur_digit);
		end
	end

endmodule

// ==== src/uart_rx.sv ====
// 8N1 receiver, CLKS_PER_BIT must be even and at least 4
// a low stop bit drops the byte without any error flag
`include "board_config.svh"

module uart_rx import board_pkg::*; (
	input  logic  sys_clk,
	input  logic  sys_rst_n,
	input  logic  uart_rx_port,
	output byte_t rx_data,
	output logic  rx_valid
);

	localparam int CNT_W = $clog2(`CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(`CLKS_PER_BIT / 2 - 1);
	localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`CLKS_PER_BIT - 1);

	rx_state_t        rx_state;
	logic             rx_s1;
	logic             rx_s2;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0]       bit_idx;
	byte_t            rx_shift;
	logic             bit_tick;
	logic             data_sample;
	logic             stop_ok;

	assign bit_tick    = (clk_cnt == FULL_BIT);
	assign data_sample = (rx_state == rx_st_data) && bit_tick;
	assign stop_ok     = (rx_state == rx_st_stop) && bit_tick && rx_s2;

	// line idles high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_s1 <= 1'b1;
			rx_s2 <= 1'b1;
		end else begin
			rx_s1 <= uart_rx_port;
			rx_s2 <= rx_s1;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_state <= rx_st_idle;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (rx_state)
				rx_st_idle: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					if (!rx_s2) begin
						rx_state <= rx_st_start;
					end
				end
				rx_st_start: begin
					// still low at mid-bit, else a glitch
					if (clk_cnt == HALF_BIT) begin
						clk_cnt  <= '0;
						rx_state <= rx_s2 ? rx_st_idle : rx_st_data;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				rx_st_data: begin
					if (bit_tick) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							rx_state <= rx_st_stop;
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				rx_st_stop: begin
					if (bit_tick) begin
						clk_cnt  <= '0;
						rx_valid <= stop_ok;
						rx_state <= rx_st_idle;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: rx_state <= rx_st_idle;
			endcase
		end
	end

	// lsb first
	always_ff @(posedge sys_clk) begin
		if (data_sample) begin
			rx_shift <= {rx_s2, rx_shift[7:1]};
		end
		if (stop_ok) begin
			rx_data <= rx_shift;
		end
	end

endmodule

// ==== src/uart_tx.sv ====
// 8N1 transmitter, a frame takes exactly 10 * CLKS_PER_BIT cycles
// tx_start is ignored while tx_ready is low
`include "board_config.svh"

module uart_tx import board_pkg::*; (
	input  logic  sys_clk,
	input  logic  sys_rst_n,
	input  logic  tx_start,
	input  byte_t tx_data,
	output logic  tx_ready,
	output logic  uart_tx_port
);

	localparam int CNT_W = $clog2(`CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`CLKS_PER_BIT - 1);

	tx_state_t        tx_state;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0]       bit_idx;
	byte_t            tx_shift;
	logic             accept;
	logic             bit_tick;

	assign tx_ready = (tx_state == tx_st_idle);
	assign accept   = tx_ready && tx_start;
	assign bit_tick = (clk_cnt == FULL_BIT);

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			tx_shift <= tx_data;
		end else if (tx_state == tx_st_data && bit_tick) begin
			tx_shift <= {1'b0, tx_shift[7:1]};
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tx_state     <= tx_st_idle;
			clk_cnt      <= '0;
			bit_idx      <= '0;
			uart_tx_port <= 1'b1;
		end else if (accept) begin
			tx_state     <= tx_st_start;
			clk_cnt      <= '0;
			bit_idx      <= '0;
			uart_tx_port <= 1'b0;
		end else if (tx_state != tx_st_idle) begin
			clk_cnt <= bit_tick ? '0 : clk_cnt + 1'b1;
			if (bit_tick) begin
				case (tx_state)
					tx_st_start: begin
						tx_state     <= tx_st_data;
						uart_tx_port <= tx_shift[0];
					end
					tx_st_data: begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							tx_state     <= tx_st_stop;
							uart_tx_port <= 1'b1;
						end else begin
							// next bit before the shift lands
							uart_tx_port <= tx_shift[1];
						end
					end
					default: tx_state <= tx_st_idle;
				endcase
			end
		end
	end

endmodule

// ==== test/board_checker.sv ====
// assertions bound into board_top, idle while sys_rst_n is low
module board_checker import board_pkg::*; (
	input logic  sys_clk,
	input logic  sys_rst_n,
	input byte_t seg_choice,
	input logic  rx_valid,
	input logic  tx_ready,
	input logic  uart_tx_port
);
	timeunit 1ns;
	timeprecision 1ps;

	// one digit driven at a time and the select steps upward
	one_digit_selected: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
			$onehot(~seg_choice) && (seg_choice == $past(seg_choice)
			|| seg_choice == {$past(seg_choice[6:0]), $past(seg_choice[7])})
	) else $error("seg_choice does not select exactly one digit in scan order");

	// receive strobe is a single-cycle pulse
	rx_valid_single: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n) rx_valid |=> !rx_valid
	) else $error("rx_valid stayed high for two cycles");

	// an idle transmitter keeps the line at the stop level
	tx_idle_high: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n) tx_ready |-> uart_tx_port
	) else $error("uart_tx_port is low while tx_ready is high");

endmodule

bind board_top board_checker u_board_checker (
	.sys_clk      (sys_clk),
	.sys_rst_n    (sys_rst_n),
	.seg_choice   (seg_choice),
	.rx_valid     (rx_valid),
	.tx_ready     (tx_ready),
	.uart_tx_port (uart_tx_port)
);

// ==== test/board_tb.sv ====
// testbench for board_top, inputs change on rising edges, outputs sampled on falling edges
// stops at the first mismatch, waits are derived from the timing macros
`include "board_config.svh"

module board_tb import board_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int beep_window = `BEEP_CLKS + `DEBOUNCE_CLKS;
	localparam int echo_wait   = 12 * `CLKS_PER_BIT;
	// 20 single frames plus the back-to-back pair, and 12 presses
	localparam int frame_cyc   = 20 * `CLKS_PER_BIT + 10 * `SCAN_CLKS;
	localparam int press_cyc   = 2 * beep_window + 3 * `DEBOUNCE_CLKS;
	localparam int cycle_limit = 2 * (22 * frame_cyc + 12 * press_cyc);

	logic   sys_clk;
	logic   sys_rst_n;
	key_t   key_in;
	logic   uart_rx_port;
	logic   bepeer;
	byte_t  led;
	seg_t   seg_number;
	byte_t  seg_choice;
	logic   uart_tx_port;

	integer seed = 32'h98ed_c965;
	int     cycle_count = 0;
	byte_t  echo_q[$];
	key_t   model_led;
	count_t model_count;
	byte_t  model_rx;

	board_top u_dut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.key_in       (key_in),
		.uart_rx_port (uart_rx_port),
		.bepeer       (bepeer),
		.led          (led),
		.seg_number   (seg_number),
		.seg_choice   (seg_choice),
		.uart_tx_port (uart_tx_port)
	);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped");
	endtask

	always @(posedge sys_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			abort_run($sformatf("timeout: test still running after %0d cycles", cycle_limit));
		end
	end

	task automatic check_byte(input string name, input byte_t actual, input byte_t expected);
		if (actual !== expected) begin
			abort_run($sformatf("CHECK FAILED %s: got 0x%02h, expected 0x%02h",
				name, actual, expected));
		end
	endtask

	task automatic check_count(input string name, input count_t actual, input count_t expected);
		if (actual !== expected) begin
			abort_run($sformatf("CHECK FAILED %s: got 0x%01h, expected 0x%01h",
				name, actual, expected));
		end
	endtask

	task automatic check_seg(input string name, input seg_t actual, input seg_t expected);
		if (actual !== expected) begin
			abort_run($sformatf("CHECK FAILED %s: got 0x%02h, expected 0x%02h",
				name, actual, expected));
		end
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			abort_run($sformatf("CHECK FAILED %s: got 0x%01h, expected 0x%01h",
				name, actual, expected));
		end
	endtask

	// active-low a..g with dp off, 10 blank, 11 dash
	function automatic seg_t exp_glyph(input digit_t code);
		case (code)
			4'd0:    return 8'hc0;
			4'd1:    return 8'hf9;
			4'd2:    return 8'ha4;
			4'd3:    return 8'hb0;
			4'd4:    return 8'h99;
			4'd5:    return 8'h92;
			4'd6:    return 8'h82;
			4'd7:    return 8'hf8;
			4'd8:    return 8'h80;
			4'd9:    return 8'h90;
			4'd10:   return 8'hff;
			4'd11:   return 8'hbf;
			4'd12:   return 8'hc6;
			4'd13:   return 8'ha1;
			4'd14:   return 8'h86;
			default: return 8'h8e;
		endcase
	endfunction

	// layout from digit 7 down: F, blank, dash, count, blank, blank, rx hi, rx lo
	function automatic digit_t model_digit(input int idx);
		case (idx)
			7:       return 4'd15;
			6, 3, 2: return 4'd10;
			5:       return 4'd11;
			4:       return model_count;
			1:       return model_rx[7:4];
			default: return model_rx[3:0];
		endcase
	endfunction

	// -1 unless exactly one select line is low
	function automatic int choice_index(input byte_t choice);
		int idx;
		int lows;
		idx = -1;
		lows = 0;
		for (int i = 0; i < 8; i++) begin
			if (!choice[i]) begin
				idx = i;
				lows++;
			end
		end
		return (lows == 1) ? idx : -1;
	endfunction

	task automatic check_scan();
		byte_t seen;
		int    idx;
		seen = '0;
		repeat (8 * `SCAN_CLKS) begin
			@(negedge sys_clk);
			idx = choice_index(seg_choice);
			if (idx < 0) begin
				abort_run("seg_choice does not select exactly one digit");
			end
			check_seg($sformatf("seg_number digit %0d", idx), seg_number,
				exp_glyph(model_digit(idx)));
			seen = seen | (byte_t'(1) << idx);
		end
		check_byte("digits scanned", seen, 8'hff);
	endtask

	// start, eight data bits lsb first, stop
	task automatic send_frame(input byte_t data);
		logic [9:0] frame;
		frame = {1'b1, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge sys_clk);
			uart_rx_port <= frame[i];
			repeat (`CLKS_PER_BIT - 1) @(posedge sys_clk);
		end
	endtask

	// samples the echo line at mid-bit
	task automatic receive_echo(output byte_t data);
		@(negedge sys_clk);
		while (sys_rst_n !== 1'b1 || uart_tx_port !== 1'b0) begin
			@(negedge sys_clk);
		end
		repeat (`CLKS_PER_BIT / 2) @(negedge sys_clk);
		if (uart_tx_port !== 1'b0) begin
			abort_run("echo start bit did not stay low to mid-bit");
		end
		for (int i = 0; i < 8; i++) begin
			repeat (`CLKS_PER_BIT) @(negedge sys_clk);
			data[i] = uart_tx_port;
		end
		repeat (`CLKS_PER_BIT) @(negedge sys_clk);
		if (uart_tx_port !== 1'b1) begin
			abort_run("echo frame has a low stop bit");
		end
	endtask

	initial begin : echo_monitor
		byte_t rx_byte;
		forever begin
			receive_echo(rx_byte);
			echo_q.push_back(rx_byte);
		end
	end

	task automatic wait_echo();
		int waited;
		waited = 0;
		while (echo_q.size() == 0) begin
			@(posedge sys_clk);
			waited++;
			if (waited > echo_wait) begin
				abort_run("no echo frame appeared on uart_tx_port");
			end
		end
	endtask

	// bounce glitches, then a held press, beep watched over the whole window
	task automatic press_key(input int key_idx);
		int   glitches;
		int   hold;
		logic toggled;
		glitches = $unsigned($random(seed)) % 4;
		for (int g = 0; g < glitches; g++) begin
			@(posedge sys_clk);
			key_in <= ~(key_t'(1) << key_idx);
			repeat ($unsigned($random(seed)) % 3) @(posedge sys_clk);
			@(posedge sys_clk);
			key_in <= '1;
			repeat (1 + $unsigned($random(seed)) % 4) @(posedge sys_clk);
		end
		hold = `DEBOUNCE_CLKS + 4 + $unsigned($random(seed)) % 16;
		toggled = 1'b0;
		@(posedge sys_clk);
		key_in <= ~(key_t'(1) << key_idx);
		for (int c = 1; c <= 2 * beep_window; c++) begin
			@(posedge sys_clk);
			if (c == hold) begin
				key_in <= '1;
			end
			@(negedge sys_clk);
			if (c <= beep_window && bepeer) begin
				toggled = 1'b1;
			end
		end
		model_led = model_led ^ (key_t'(1) << key_idx);
		model_count = model_count + 1'b1;
		if (!toggled) begin
			abort_run($sformatf("bepeer did not toggle within %0d cycles of a press", beep_window));
		end
		check_bit("bepeer", bepeer, 1'b0);
		check_byte("led", led, {model_count, model_led});
		check_count("press_count", u_dut.press_count, model_count);
		check_scan();
	endtask

	task automatic run_reset_checks();
		@(negedge sys_clk);
		check_bit("uart_tx_port", uart_tx_port, 1'b1);
		check_bit("bepeer", bepeer, 1'b0);
		check_byte("led", led, 8'h00);
		check_byte("seg_choice", seg_choice, 8'hfe);
		check_seg("seg_number", seg_number, 8'hff);
		@(posedge sys_clk);
		sys_rst_n <= 1'b1;
		// first active edge still shows the reset dash on digit 0
		@(posedge sys_clk);
		@(negedge sys_clk);
		check_byte("seg_choice", seg_choice, 8'hfe);
		check_seg("seg_number digit 0", seg_number, exp_glyph(4'd11));
		check_scan();
	endtask

	initial begin : stimulus
		byte_t data;
		byte_t first;
		byte_t echo;
		sys_rst_n = 1'b0;
		key_in = '1;
		uart_rx_port = 1'b1;
		model_led = '0;
		model_count = '0;
		model_rx = '0;
		run_reset_checks();
		for (int n = 0; n < 20; n++) begin
			data = byte_t'($random(seed));
			send_frame(data);
			model_rx = data;
			wait_echo();
			echo = echo_q.pop_front();
			check_byte("echo byte", echo, data);
			check_scan();
		end
		for (int n = 0; n < 12; n++) begin
			press_key($unsigned($random(seed)) % 4);
		end
		// second byte lands while the echo of the first is still going out
		first = byte_t'($random(seed));
		data = byte_t'($random(seed));
		send_frame(first);
		send_frame(data);
		model_rx = data;
		wait_echo();
		echo = echo_q.pop_front();
		check_byte("echo byte", echo, first);
		repeat (echo_wait) @(posedge sys_clk);
		if (echo_q.size() != 0) begin
			abort_run("byte received while the transmitter was busy was echoed");
		end
		check_scan();
		$display("Result: PASSED");
		$finish;
	end

endmodule
